//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;
  typedef logic [2:0]  alu_op_t;

  // primary opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDI  = 6'h08;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // r-type function codes
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;

  // internal alu encodings
  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_SLT = 3'd4;

  // memory depths, in words
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // jal return address lands here
  localparam reg_addr_t LINK_REG = 5'd31;

  // decoded control, one bit per datapath choice
  typedef struct packed {
    logic    reg_dest;
    logic    alu_src;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump;
    logic    link;
    alu_op_t alu_op;
  } ctrl_t;

  // what the retiring instruction changes at the next edge
  typedef struct packed {
    word_t     pc;
    logic      reg_we;
    reg_addr_t reg_addr;
    word_t     reg_data;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_data;
  } retire_t;

endpackage

`default_nettype wire

//--- list.f
common/mips_pkg.sv
src/fetch_unit.sv
src/control_unit.sv
src/register_file.sv
src/exec_unit.sv
src/mem_stage.sv
src/mips_cpu.sv
sim/cpu_checker.sv
sim/tb_mips_cpu.sv

//--- run.sh
#!/bin/sh
# build and run the mips core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_mips_cpu -f list.f -o tb_mips_cpu

./obj_dir/tb_mips_cpu > sim.log 2>&1
cat sim.log

if grep -q "^all tests passed$" sim.log; then
  exit 0
else
  exit 1
fi

//--- sim/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import mips_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  wire          retire_valid,
  input  wire retire_t retire,
  output logic         done,
  output int           errors,
  output int           pending
);

  localparam string TRACE_FILE = "sim/program_trace.txt";

  // expected register writes, in retire order
  string     reg_tag [$];
  reg_addr_t reg_num [$];
  word_t     reg_val [$];
  // expected stores
  string     mem_tag [$];
  word_t     mem_adr [$];
  word_t     mem_val [$];

  // loaded program, byte address to instruction word
  word_t prog [word_t];

  // legal pcs for the next retire, they differ only after a branch
  word_t next_pc = '0;
  word_t alt_pc  = '0;

  logic loaded       = 1'b0;
  int   setup_errors = 0;
  int   mismatches   = 0;

  assign errors = setup_errors + mismatches;

  initial begin
    int        fd;
    int        n;
    string     line;
    string     kind;
    string     tag;
    reg_addr_t rnum;
    word_t     a;
    word_t     v;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s, nothing to compare against", TRACE_FILE);
      setup_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) == "R") begin
          n = $sscanf(line, "%s %s %d %h", kind, tag, rnum, v);
          if (n == 4) begin
            reg_tag.push_back(tag);
            reg_num.push_back(rnum);
            reg_val.push_back(v);
          end
        end else if (n > 0 && line.getc(0) == "M") begin
          n = $sscanf(line, "%s %s %h %h", kind, tag, a, v);
          if (n == 4) begin
            mem_tag.push_back(tag);
            mem_adr.push_back(a);
            mem_val.push_back(v);
          end
        end else if (n > 0 && line.getc(0) == "P") begin
          n = $sscanf(line, "%s %s %h %h", kind, tag, a, v);
          if (n == 4) begin
            prog[a] = v;
          end
        end
      end
      $fclose(fd);
      if (reg_num.size() == 0 && mem_adr.size() == 0) begin
        $display("trace holds no expected register or memory writes");
        setup_errors++;
      end
    end
    loaded = 1'b1;
  end

  task automatic check_reg();
    if (reg_num.size() == 0) begin
      $display("unexpected write of %h to r%0d at pc %h",
               retire.reg_data, retire.reg_addr, retire.pc);
      mismatches++;
    end else begin
      if (retire.reg_addr !== reg_num[0]) begin
        $display("ERR %s expected r%0d actual r%0d", reg_tag[0], reg_num[0], retire.reg_addr);
        mismatches++;
      end
      if (retire.reg_data !== reg_val[0]) begin
        $display("ERR %s expected %h actual %h", reg_tag[0], reg_val[0], retire.reg_data);
        mismatches++;
      end
      void'(reg_tag.pop_front());
      void'(reg_num.pop_front());
      void'(reg_val.pop_front());
    end
  endtask

  task automatic check_mem();
    if (mem_adr.size() == 0) begin
      $display("unexpected store of %h to %h at pc %h",
               retire.mem_data, retire.mem_addr, retire.pc);
      mismatches++;
    end else begin
      if (retire.mem_addr !== mem_adr[0]) begin
        $display("ERR %s expected %h actual %h", mem_tag[0], mem_adr[0], retire.mem_addr);
        mismatches++;
      end
      if (retire.mem_data !== mem_val[0]) begin
        $display("ERR %s expected %h actual %h", mem_tag[0], mem_val[0], retire.mem_data);
        mismatches++;
      end
      void'(mem_tag.pop_front());
      void'(mem_adr.pop_front());
      void'(mem_val.pop_front());
    end
  endtask

  // pc flow from the program words, first retire at address 0
  task automatic check_pc();
    word_t w;
    word_t seq;
    if (retire.pc !== next_pc && retire.pc !== alt_pc) begin
      if (next_pc == alt_pc) begin
        $display("ERR pc_flow expected %h actual %h", next_pc, retire.pc);
      end else begin
        $display("ERR pc_flow expected %h or %h actual %h", next_pc, alt_pc, retire.pc);
      end
      mismatches++;
    end
    seq     = retire.pc + 32'd4;
    next_pc = seq;
    alt_pc  = seq;
    if (!prog.exists(retire.pc)) begin
      $display("pc %h retired outside the loaded program", retire.pc);
      mismatches++;
    end else begin
      w = prog[retire.pc];
      case (w[31:26])
        OP_J, OP_JAL: begin
          // region of the sequential pc, word index below it
          next_pc = {seq[31:28], 28'd0} | (32'(w[25:0]) << 2);
          alt_pc  = next_pc;
        end
        OP_BEQ, OP_BNE: begin
          // taken or not shows in the register writes
          alt_pc = seq + (32'($signed(w[15:0])) << 2);
        end
        default: ;
      endcase
    end
  endtask

  // retire fields are settled by the falling edge
  always @(negedge clk) begin
    if (!reset && retire_valid) begin
      check_pc();
      // r0 writes are dropped by the core
      if (retire.reg_we && retire.reg_addr != '0) begin
        check_reg();
      end
      if (retire.mem_we) begin
        check_mem();
      end
    end
    done    <= loaded && (reg_num.size() == 0) && (mem_adr.size() == 0);
    pending <= reg_num.size() + mem_adr.size();
  end

endmodule

`default_nettype wire

//--- sim/program_trace.txt
# P <tag> <byte address> <instruction word>
# R <tag> <register> <value>, M <tag> <byte address> <value>, all in retire order
P prog 00000000 20010006
P prog 00000004 2002fffd
P prog 00000008 00221820
P prog 0000000c 00222022
P prog 00000010 00222824
P prog 00000014 00223025
P prog 00000018 0041382a
P prog 0000001c 0022402a
P prog 00000020 20200007
P prog 00000024 00014820
P prog 00000028 200a0040
P prog 0000002c ad440004
P prog 00000030 ad46fffc
P prog 00000034 8d4b0004
P prog 00000038 8d4cfffc
P prog 0000003c 10290001
P prog 00000040 200d0111
P prog 00000044 10220001
P prog 00000048 200d0022
P prog 0000004c 14220001
P prog 00000050 200e0333
P prog 00000054 14290001
P prog 00000058 200e0044
P prog 0000005c 08000019
P prog 00000060 20100555
P prog 00000064 0c00001b
P prog 00000068 20110777
P prog 0000006c 23f20008
P prog 00000070 0800001c
R addi_pos 1 00000006
R addi_neg 2 fffffffd
R add 3 00000003
R sub 4 00000009
R and 5 00000004
R or 6 ffffffff
R slt_neg 7 00000001
R slt_pos 8 00000000
R r0_read 9 00000006
R addi_base 10 00000040
M sw_pos 00000044 00000009
M sw_neg 0000003c ffffffff
R lw_pos 11 00000009
R lw_neg 12 ffffffff
R beq_pair 13 00000022
R bne_pair 14 00000044
R jal_link 31 00000068
R jal_target 18 00000070

//--- sim/tb_mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu import mips_pkg::*; ();

  localparam string TRACE_FILE   = "sim/program_trace.txt";
  localparam int    RESET_CYCLES = 8;

  logic    clk;
  logic    reset;
  logic    load_en;
  word_t   load_addr;
  word_t   load_data;
  logic    retire_valid;
  retire_t retire;

  // checker status
  logic done;
  int   errors;
  int   pending;

  // program image from the P lines
  word_t prog_addr [$];
  word_t prog_word [$];

  int   setup_errors = 0;
  int   limit;
  int   cycles;
  logic timed_out = 1'b0;

  mips_cpu u_dut (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  cpu_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .retire_valid (retire_valid),
    .retire       (retire),
    .done         (done),
    .errors       (errors),
    .pending      (pending)
  );

  // 10 ns period
  initial clk = 1'b0;
  always #5 clk = ~clk;

  // pull the program words out of the trace
  task automatic read_program();
    int    fd;
    int    n;
    string line;
    string kind;
    string tag;
    word_t addr;
    word_t data;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s, no program to load", TRACE_FILE);
      setup_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) == "P") begin
        n = $sscanf(line, "%s %s %h %h", kind, tag, addr, data);
        if (n == 4) begin
          prog_addr.push_back(addr);
          prog_word.push_back(data);
        end
      end
    end
    $fclose(fd);
    if (prog_addr.size() == 0) begin
      $display("trace holds no program words");
      setup_errors++;
    end
  endtask

  // one word per cycle while reset is high
  // reset lasts at least RESET_CYCLES, longer if the program needs it
  task automatic load_program();
    int idx;
    int n;
    idx = 0;
    n   = 0;
    while (n < RESET_CYCLES || idx < prog_addr.size()) begin
      @(posedge clk);
      #1;
      if (idx < prog_addr.size()) begin
        load_en   = 1'b1;
        load_addr = prog_addr[idx];
        load_data = prog_word[idx];
        idx++;
      end else begin
        load_en = 1'b0;
      end
      n++;
    end
    // last word lands at this edge
    @(posedge clk);
    #1;
    load_en = 1'b0;
    reset   = 1'b0;
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    read_program();
    load_program();
    // a few cycles per instruction plus slack
    limit  = 4 * prog_addr.size() + 50;
    cycles = 0;
    while (done !== 1'b1 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      timed_out = 1'b1;
      $display("timeout after %0d cycles, the expected writes did not all occur", cycles);
    end
    $display("mismatches %0d, setup errors %0d, timeouts %0d, events left %0d",
             errors, setup_errors, int'(timed_out), pending);
    if (errors == 0 && setup_errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import mips_pkg::*; (
  input  wire opcode_t opcode,
  input  wire funct_t  funct,
  output ctrl_t        ctrl
);

  // anything not listed stays all zero, a no-op
  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_RTYPE: begin
        // unknown funct leaves reg_write low
        ctrl.reg_dest = 1'b1;
        case (funct)
          FN_ADD: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_ADD;
          end
          FN_SUB: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_SUB;
          end
          FN_AND: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_AND;
          end
          FN_OR: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_OR;
          end
          FN_SLT: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALU_SLT;
          end
          default: ctrl.reg_dest = 1'b0;
        endcase
      end
      OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      OP_LW: begin
        // address = base + offset
        ctrl.alu_src    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_op     = ALU_ADD;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      // compare through subtract, zero flag decides
      OP_BEQ: begin
        ctrl.branch_eq = 1'b1;
        ctrl.alu_op    = ALU_SUB;
      end
      OP_BNE: begin
        ctrl.branch_ne = 1'b1;
        ctrl.alu_op    = ALU_SUB;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        // return address written by mem_stage
        ctrl.jump      = 1'b1;
        ctrl.link      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import mips_pkg::*; (
  input  wire word_t read_a,
  input  wire word_t read_b,
  input  wire imm_t  imm,
  input  wire ctrl_t ctrl,
  output word_t      alu_result,
  output logic       zero,
  output word_t      ext_imm
);

  word_t op_b;
  logic  less;

  // sign extension, also feeds the branch adder
  assign ext_imm = {{16{imm[15]}}, imm};

  // immediate forms take ext_imm as second operand
  assign op_b = ctrl.alu_src ? ext_imm : read_b;

  // signed compare for slt
  assign less = $signed(read_a) < $signed(op_b);

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD: begin
        alu_result = read_a + op_b;
      end
      ALU_SUB: begin
        // beq/bne compare here too
        alu_result = read_a - op_b;
      end
      ALU_AND: begin
        alu_result = read_a & op_b;
      end
      ALU_OR: begin
        alu_result = read_a | op_b;
      end
      ALU_SLT: begin
        alu_result = {31'd0, less};
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

  // branch condition source
  assign zero = (alu_result == '0);

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import mips_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        load_en,
  input  wire word_t load_addr,
  input  wire word_t load_data,
  input  wire ctrl_t ctrl,
  input  wire        zero,
  input  wire word_t ext_imm,
  output word_t      pc,
  output word_t      pc_plus4,
  output word_t      instr
);

  // program store, filled from the load port
  word_t imem [IMEM_WORDS];

  word_t branch_target;
  word_t jump_target;
  word_t pc_next;
  logic  branch_taken;

  // word load, honoured only during reset
  always_ff @(posedge clk) begin
    if (reset && load_en) begin
      imem[load_addr[IMEM_AW+1:2]] <= load_data;
    end
  end

  // async fetch
  assign instr = imem[pc[IMEM_AW+1:2]];

  assign pc_plus4      = pc + 32'd4;
  // offset counts words from the delay slot address
  assign branch_target = pc_plus4 + {ext_imm[29:0], 2'b00};
  // region bits from pc+4, target in words
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

  assign branch_taken = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

  always_comb begin
    if (ctrl.jump) begin
      pc_next = jump_target;
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // every pc we step to must be a fetchable word
  a_pc_in_imem : assert property (@(posedge clk) disable iff (reset)
    1'b1 |=> (pc[1:0] == 2'b00) && (pc < word_t'(IMEM_WORDS * 4)))
    else $error("pc %h misaligned or outside instruction memory", pc);

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mips_pkg::*; (
  input  wire            clk,
  input  wire            reset,
  input  wire ctrl_t     ctrl,
  input  wire word_t     alu_result,
  input  wire word_t     store_data,
  input  wire word_t     pc_plus4,
  input  wire reg_addr_t rt,
  input  wire reg_addr_t rd,
  output reg_addr_t      wb_addr,
  output word_t          wb_data
);

  word_t dmem [DMEM_WORDS];
  word_t mem_rdata;

  // word index from the byte address
  logic [DMEM_AW-1:0] word_idx;
  assign word_idx = alu_result[DMEM_AW+1:2];

  // store at the edge, blocked while reset is high
  always_ff @(posedge clk) begin
    if (!reset && ctrl.mem_write) begin
      dmem[word_idx] <= store_data;
    end
  end

  assign mem_rdata = dmem[word_idx];

  // jal overrides both destination and data
  assign wb_addr = ctrl.link ? LINK_REG : (ctrl.reg_dest ? rd : rt);
  assign wb_data = ctrl.link ? pc_plus4 : (ctrl.mem_to_reg ? mem_rdata : alu_result);

  // loads and stores need an aligned in-range address
  a_dmem_aligned : assert property (@(posedge clk) disable iff (reset)
    (ctrl.mem_read || ctrl.mem_write) |->
      (alu_result[1:0] == 2'b00) && (alu_result < word_t'(DMEM_WORDS * 4)))
    else $error("data access at %h misaligned or out of range", alu_result);

endmodule

`default_nettype wire

//--- src/mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu import mips_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  // instruction load, only while reset is high
  input  wire        load_en,
  input  wire word_t load_addr,
  input  wire word_t load_data,
  // one retire per cycle out of reset
  output logic       retire_valid,
  output retire_t    retire
);

  word_t     pc;
  word_t     pc_plus4;
  word_t     instr;
  ctrl_t     ctrl;
  word_t     read_a;
  word_t     read_b;
  word_t     alu_result;
  word_t     ext_imm;
  logic      zero;
  reg_addr_t wb_addr;
  word_t     wb_data;

  // instruction fields
  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  imm_t      imm;

  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = instr[15:0];
  assign funct  = instr[5:0];

  fetch_unit u_fetch (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .ctrl      (ctrl),
    .zero      (zero),
    .ext_imm   (ext_imm),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .instr     (instr)
  );

  control_unit u_control (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  register_file u_regs (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs),
    .rt_addr (rt),
    .wr_en   (ctrl.reg_write),
    .wr_addr (wb_addr),
    .wr_data (wb_data),
    .read_a  (read_a),
    .read_b  (read_b)
  );

  exec_unit u_exec (
    .read_a     (read_a),
    .read_b     (read_b),
    .imm        (imm),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .zero       (zero),
    .ext_imm    (ext_imm)
  );

  mem_stage u_mem (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .store_data (read_b),
    .pc_plus4   (pc_plus4),
    .rt         (rt),
    .rd         (rd),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data)
  );

  // core retires every cycle once out of reset
  assign retire_valid = ~reset;

  // state update seen at the coming edge
  assign retire.pc       = pc;
  assign retire.reg_we   = ctrl.reg_write;
  assign retire.reg_addr = wb_addr;
  assign retire.reg_data = wb_data;
  assign retire.mem_we   = ctrl.mem_write;
  assign retire.mem_addr = alu_result;
  assign retire.mem_data = read_b;

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import mips_pkg::*; (
  input  wire            clk,
  input  wire            reset,
  input  wire reg_addr_t rs_addr,
  input  wire reg_addr_t rt_addr,
  input  wire            wr_en,
  input  wire reg_addr_t wr_addr,
  input  wire word_t     wr_data,
  output word_t          read_a,
  output word_t          read_b
);

  word_t regs [32];

  // reset has priority, so no write lands during reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      // r0 is never written
      regs[wr_addr] <= wr_data;
    end
  end

  // async read ports
  assign read_a = regs[rs_addr];
  assign read_b = regs[rt_addr];

endmodule

`default_nettype wire
